//--- Bender.yml
package:
  name: ntt_stage

sources:
  - include_dirs:
      - .
    files:
      - ntt_coeff_pkg.sv
      - ntt_ctrl_pkg.sv
      - ntt_pair_if.sv
      - ntt_transpose_buffer.sv
      - ntt_ct_butterfly.sv
      - ntt_lane_merge.sv
      - ntt_stage_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clk_gen.sv
      - tb_ntt_stage.sv

//--- ntt_coeff_pkg.sv
//========================================
// arithmetic data types for coefficients and words
//========================================
`include "ntt_consts.svh"

package ntt_coeff_pkg;

    // one reduced coefficient, always below NTT_Q
    typedef logic [`NTT_REG_SIZE-1:0] coeff_t;

    // one extra bit so that a modular sum or difference can be
    // formed before the final correction step
    typedef logic [`NTT_REG_SIZE:0] sum_t;

    // full product of a coefficient and the twiddle factor
    // this is kept unreduced across the first pipeline stage
    typedef logic [2*`NTT_REG_SIZE-1:0] prod_t;

    // four coefficients in one stream word
    // coefficient 0 sits in the lowest bits
    typedef logic [`NTT_BLOCK_WORDS*`NTT_REG_SIZE-1:0] coeff_word_t;

endpackage

//--- ntt_consts.svh
//========================================
// shared width, modulus and block size macros for the NTT stage
//========================================
`ifndef NTT_CONSTS_SVH
`define NTT_CONSTS_SVH

// width of one coefficient in bits
`define NTT_REG_SIZE 23

// prime modulus of the ring, 2^23 - 2^13 + 1
`define NTT_Q 8380417

// words collected before a block is transposed
// this also equals the coefficients per word, so the block is square
`define NTT_BLOCK_WORDS 4

// butterfly lanes behind the transpose buffer
// each lane takes one pair out of a four coefficient column
`define NTT_NUM_LANES 2

`endif

//--- ntt_ct_butterfly.sv
//========================================
// two stage pipelined Cooley-Tukey butterfly modulo NTT_Q
//========================================
`timescale 1ns/1ps
`include "ntt_consts.svh"

module ntt_ct_butterfly
    import ntt_coeff_pkg::*;
(
    input  logic    clk,
    input  logic    reset_n,
    input  logic    zeroize_i,
    input  coeff_t  twiddle_i,
    ntt_pair_if.sink pair_i,
    ntt_pair_if.src  pair_o
);

    // stage 1 holds u and the raw product w*v
    logic   s1_valid;
    coeff_t s1_u;
    prod_t  s1_prod;

    // stage 2 holds the finished butterfly outputs
    logic   s2_valid;
    coeff_t s2_sum;
    coeff_t s2_diff;

    logic   pipe_en;
    coeff_t wv_mod;
    sum_t   add_raw;
    sum_t   sub_raw;
    coeff_t add_mod;
    coeff_t sub_mod;

    //========================================
    // stall control
    //========================================

    // both stages stop together when stage 2 holds a result nobody takes
    // bubbles in stage 2 are therefore always filled
    assign pipe_en      = !s2_valid || pair_o.ready;
    assign pair_i.ready = pipe_en;

    //========================================
    // stage 1, multiply
    //========================================
    always_ff @(posedge clk) begin
        if (pipe_en) begin
            s1_u    <= pair_i.u;
            s1_prod <= prod_t'(twiddle_i) * prod_t'(pair_i.v);
        end
    end

    //========================================
    // stage 2, reduce and add or subtract
    //========================================

    // the remainder is below NTT_Q, so it fits a coefficient
    assign wv_mod = coeff_t'(s1_prod % prod_t'(`NTT_Q));

    // u + w*v is below 2q, one conditional subtract brings it back
    assign add_raw = sum_t'(s1_u) + sum_t'(wv_mod);
    assign add_mod = (add_raw >= sum_t'(`NTT_Q)) ?
                     coeff_t'(add_raw - sum_t'(`NTT_Q)) : coeff_t'(add_raw);

    // u - w*v goes negative when w*v is larger, then q is added back
    assign sub_raw = sum_t'(s1_u) - sum_t'(wv_mod);
    assign sub_mod = (s1_u < wv_mod) ?
                     coeff_t'(sub_raw + sum_t'(`NTT_Q)) : coeff_t'(sub_raw);

    always_ff @(posedge clk) begin
        if (pipe_en) begin
            s2_sum  <= add_mod;
            s2_diff <= sub_mod;
        end
    end

    // valid bits run alongside the data and see the same enable
    always_ff @(posedge clk) begin
        if (!reset_n || zeroize_i) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else if (pipe_en) begin
            s1_valid <= pair_i.valid;
            s2_valid <= s1_valid;
        end
    end

    assign pair_o.valid = s2_valid;
    assign pair_o.u     = s2_sum;
    assign pair_o.v     = s2_diff;

endmodule

//--- ntt_ctrl_pkg.sv
//========================================
// control types for the transpose buffer
//========================================
`include "ntt_consts.svh"

package ntt_ctrl_pkg;

    // counts words while filling and columns while draining
    typedef logic [$clog2(`NTT_BLOCK_WORDS)-1:0] word_cnt_t;

    // one bit per butterfly lane
    typedef logic [`NTT_NUM_LANES-1:0] lane_mask_t;

    // the buffer either collects a block or hands it out
    typedef enum logic {
        BUF_FILL  = 1'b0,
        BUF_DRAIN = 1'b1
    } buf_state_t;

endpackage

//--- ntt_input.hex
// one line per word, coefficients 0 to 3 from left to right
// line 1 is the twiddle, then per block four input rows and four expected words
7FE000
// block 0, small values whose differences go negative
000001 000002 000003 000004
000010 000020 000030 000040
000100 000200 000300 000400
001000 002000 003000 004000
7FDF02 7FD011 000101 001010
7FDE03 7FC021 000202 002020
7FDD04 7FB031 000303 003030
7FDC05 7FA041 000404 004040
// block 1, values near q whose sums wrap
7FE000 700000 400000 123456
7FDFFF 654321 3FFFFF 000000
000001 100000 400001 7FE000
7FE000 1ABCDE 400003 000000
7FDFFF 7FE000 000000 7FDFFE
600000 4A8643 001FFF 001FFE
7FE000 7FDFFD 002000 002001
123457 000000 123455 000000
// block 2, mixed values
0ABCDE 200000 000000 3C0000
111111 000005 7FE000 222222
0ABCDE 300000 000007 2C0000
222222 000003 7FE000 111111
000000 6ECEF0 1579BC 333333
6FE001 000002 500000 000008
7FDFFA 000000 000007 7FDFFF
100000 111111 680000 333333

//--- ntt_lane_merge.sv
//========================================
// joins both lane results into one registered output word
//========================================
`timescale 1ns/1ps
`include "ntt_consts.svh"

module ntt_lane_merge
    import ntt_coeff_pkg::*;
(
    input  logic        clk,
    input  logic        reset_n,
    input  logic        zeroize_i,
    ntt_pair_if.sink    pair_i [`NTT_NUM_LANES],
    output logic        out_valid_o,
    input  logic        out_ready_i,
    output coeff_word_t out_data_o
);

    logic [`NTT_NUM_LANES-1:0] lane_valid;
    coeff_t [`NTT_NUM_LANES-1:0] lane_u;
    coeff_t [`NTT_NUM_LANES-1:0] lane_v;
    logic out_free;
    logic join_en;

    // the register can load when it is empty or drains on this edge
    assign out_free = !out_valid_o || out_ready_i;

    // both lanes must offer a pair, then both are taken on the same edge
    assign join_en = (&lane_valid) && out_free;

    for (genvar l = 0; l < `NTT_NUM_LANES; l++) begin : g_lane_in
        assign lane_valid[l] = pair_i[l].valid;
        assign lane_u[l]     = pair_i[l].u;
        assign lane_v[l]     = pair_i[l].v;
        assign pair_i[l].ready = join_en;
    end

    //========================================
    // output register
    //========================================

    // word layout from high to low is v1, v0, u1, u0
    // held unchanged while out_ready_i is low
    always_ff @(posedge clk) begin
        if (zeroize_i) begin
            out_data_o <= '0;
        end else if (join_en) begin
            out_data_o <= {lane_v[1], lane_v[0], lane_u[1], lane_u[0]};
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n || zeroize_i) begin
            out_valid_o <= 1'b0;
        end else if (join_en) begin
            out_valid_o <= 1'b1;
        end else if (out_ready_i) begin
            out_valid_o <= 1'b0;
        end
    end

endmodule

//--- ntt_pair_if.sv
//========================================
// coefficient pair link with valid/ready handshake
//========================================
`timescale 1ns/1ps

interface ntt_pair_if
    import ntt_coeff_pkg::*;
();

    // a pair moves on a rising edge where valid and ready are both high
    // valid and the data hold still until that edge
    logic   valid;
    logic   ready;
    coeff_t u;
    coeff_t v;

    // side that produces pairs
    modport src (
        output valid,
        output u,
        output v,
        input  ready
    );

    // side that consumes pairs
    modport sink (
        input  valid,
        input  u,
        input  v,
        output ready
    );

endinterface

//--- ntt_stage_top.sv
//========================================
// NTT butterfly stage top, buffer, two lanes and merge
//========================================
`timescale 1ns/1ps
`include "ntt_consts.svh"

module ntt_stage_top
    import ntt_coeff_pkg::*;
(
    input  logic        clk,
    input  logic        reset_n,
    input  logic        zeroize_i,
    // one twiddle for the whole run, held stable by the source
    input  coeff_t      twiddle_i,
    input  logic        in_valid_i,
    output logic        in_ready_o,
    input  coeff_word_t in_data_i,
    output logic        out_valid_o,
    input  logic        out_ready_i,
    output coeff_word_t out_data_o
);

    // buffer to lane links and lane to merge links
    ntt_pair_if buf_pair [`NTT_NUM_LANES] ();
    ntt_pair_if lane_pair [`NTT_NUM_LANES] ();

    // collects a block of words and hands out its columns
    ntt_transpose_buffer i_buffer (
        .clk        (clk),
        .reset_n    (reset_n),
        .zeroize_i  (zeroize_i),
        .in_valid_i (in_valid_i),
        .in_ready_o (in_ready_o),
        .in_data_i  (in_data_i),
        .pair_o     (buf_pair)
    );

    // one butterfly per lane, all sharing the same twiddle
    for (genvar l = 0; l < `NTT_NUM_LANES; l++) begin : g_lane
        ntt_ct_butterfly i_butterfly (
            .clk       (clk),
            .reset_n   (reset_n),
            .zeroize_i (zeroize_i),
            .twiddle_i (twiddle_i),
            .pair_i    (buf_pair[l]),
            .pair_o    (lane_pair[l])
        );
    end

    // reassembles the lane results into output words
    ntt_lane_merge i_merge (
        .clk         (clk),
        .reset_n     (reset_n),
        .zeroize_i   (zeroize_i),
        .pair_i      (lane_pair),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i),
        .out_data_o  (out_data_o)
    );

endmodule

//--- ntt_transpose_buffer.sv
//========================================
// transpose buffer, four words in and four columns out as lane pairs
//========================================
`timescale 1ns/1ps
`include "ntt_consts.svh"

module ntt_transpose_buffer
    import ntt_coeff_pkg::*;
    import ntt_ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        reset_n,
    input  logic        zeroize_i,
    input  logic        in_valid_i,
    output logic        in_ready_o,
    input  coeff_word_t in_data_i,
    ntt_pair_if.src     pair_o [`NTT_NUM_LANES]
);

    // col_q[c][r] holds coefficient c of row r
    // each incoming word shifts in at the top, so row 0 ends up in slot 0
    coeff_t [`NTT_BLOCK_WORDS-1:0][`NTT_BLOCK_WORDS-1:0] col_q;
    coeff_t [`NTT_BLOCK_WORDS-1:0] in_coeff;
    coeff_t [`NTT_BLOCK_WORDS-1:0] col_sel;

    buf_state_t state;
    word_cnt_t  fill_cnt;
    word_cnt_t  col_cnt;

    // a lane sets its taken bit once it has its pair of the current column
    lane_mask_t taken;
    lane_mask_t lane_valid;
    lane_mask_t lane_ready;
    lane_mask_t lane_done;
    logic       col_done;
    logic       in_accept;

    //========================================
    // input side
    //========================================

    // no new words are taken while a block is still draining
    assign in_ready_o = (state == BUF_FILL);
    assign in_accept  = in_valid_i && in_ready_o;

    // split the word into its coefficients, coefficient 0 at index 0
    assign in_coeff = in_data_i;

    always_ff @(posedge clk) begin
        if (zeroize_i) begin
            col_q <= '0;
        end else if (in_accept) begin
            for (int c = 0; c < `NTT_BLOCK_WORDS; c++) begin
                col_q[c] <= {in_coeff[c], col_q[c][`NTT_BLOCK_WORDS-1:1]};
            end
        end
    end

    //========================================
    // drain side
    //========================================

    // the current column, row 0 in the lowest slot
    assign col_sel = col_q[col_cnt];

    // lane l takes rows l and l + NTT_NUM_LANES of the column
    for (genvar l = 0; l < `NTT_NUM_LANES; l++) begin : g_lane_out
        assign lane_valid[l]   = (state == BUF_DRAIN) && !taken[l];
        assign pair_o[l].valid = lane_valid[l];
        assign pair_o[l].u     = col_sel[l];
        assign pair_o[l].v     = col_sel[l+`NTT_NUM_LANES];
        assign lane_ready[l]   = pair_o[l].ready;
    end

    // a lane is done with the column when it took the pair earlier or takes it now
    assign lane_done = taken | (lane_valid & lane_ready);
    assign col_done  = &lane_done;

    //========================================
    // fill and drain control
    //========================================
    always_ff @(posedge clk) begin
        if (!reset_n || zeroize_i) begin
            state    <= BUF_FILL;
            fill_cnt <= '0;
            col_cnt  <= '0;
            taken    <= '0;
        end else begin
            case (state)
                BUF_FILL: begin
                    if (in_accept) begin
                        // the counter wraps back to zero on the last word
                        fill_cnt <= fill_cnt + 1'b1;
                        if (fill_cnt == word_cnt_t'(`NTT_BLOCK_WORDS-1)) begin
                            state   <= BUF_DRAIN;
                            col_cnt <= '0;
                            taken   <= '0;
                        end
                    end
                end
                BUF_DRAIN: begin
                    if (col_done) begin
                        // both lanes have the column, move on to the next one
                        taken   <= '0;
                        col_cnt <= col_cnt + 1'b1;
                        if (col_cnt == word_cnt_t'(`NTT_BLOCK_WORDS-1)) begin
                            state <= BUF_FILL;
                        end
                    end else begin
                        taken <= lane_done;
                    end
                end
                default: begin
                    state <= BUF_FILL;
                end
            endcase
        end
    end

endmodule

//--- tb.f
+incdir+.
ntt_coeff_pkg.sv
ntt_ctrl_pkg.sv
ntt_pair_if.sv
ntt_transpose_buffer.sv
ntt_ct_butterfly.sv
ntt_lane_merge.sv
ntt_stage_top.sv
tb_clk_gen.sv
tb_ntt_stage.sv

//--- tb_clk_gen.sv
//========================================
// testbench clock and reset source
//========================================
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter real PERIOD_NS    = 8.0,
    parameter int  RESET_CYCLES = 10
) (
    output logic clk_o,
    output logic reset_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
    end

    // reset is let go on a rising edge, like any other synchronous input
    initial begin
        reset_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        reset_n_o <= 1'b1;
    end

endmodule

//--- tb_ntt_stage.sv
//========================================
// testbench for the NTT stage, file driven with random back-pressure
//========================================
`timescale 1ns/1ps
`include "ntt_consts.svh"

module tb_ntt_stage
    import ntt_coeff_pkg::*;
();

    localparam int NUM_BLOCKS     = 3;
    localparam int WORDS_TOTAL    = NUM_BLOCKS * `NTT_BLOCK_WORDS;
    localparam int BLOCK_ENTRIES  = 2 * `NTT_BLOCK_WORDS * `NTT_BLOCK_WORDS;
    localparam int FILE_ENTRIES   = 1 + NUM_BLOCKS * BLOCK_ENTRIES;
    // the block that is flushed by zeroize counts as one more block
    localparam int TIMEOUT_CYCLES = 64 * (NUM_BLOCKS + 1) + 10;

    logic        clk;
    logic        reset_n;
    logic        zeroize;
    coeff_t      twiddle;
    logic        in_valid;
    logic        in_ready;
    coeff_word_t in_data;
    logic        out_valid;
    logic        out_ready;
    coeff_word_t out_data;

    // line 1 of the file is the twiddle, then 32 coefficients per block
    coeff_t      file_mem [FILE_ENTRIES];
    int          errors = 0;
    int          recv_cnt = 0;
    int          cycle_cnt;
    logic [31:0] lcg_state;
    logic        hold_prev;
    coeff_word_t data_prev;

    // results that come out before the zeroize pulse are not part of the stream
    logic        flushing;
    // forces the sink to refuse words around the zeroize pulse
    logic        hold_sink;

    tb_clk_gen i_clk_gen (
        .clk_o     (clk),
        .reset_n_o (reset_n)
    );

    ntt_stage_top i_dut (
        .clk         (clk),
        .reset_n     (reset_n),
        .zeroize_i   (zeroize),
        .twiddle_i   (twiddle),
        .in_valid_i  (in_valid),
        .in_ready_o  (in_ready),
        .in_data_i   (in_data),
        .out_valid_o (out_valid),
        .out_ready_i (out_ready),
        .out_data_o  (out_data)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // four file entries form one word, the first entry in the lowest bits
    function automatic coeff_word_t word_at(input int base);
        return {file_mem[base+3], file_mem[base+2], file_mem[base+1], file_mem[base]};
    endfunction

    function automatic int input_base(input int blk, input int row);
        return 1 + blk * BLOCK_ENTRIES + row * `NTT_BLOCK_WORDS;
    endfunction

    // expected words follow the four input rows of their block
    function automatic int expect_base(input int idx);
        return 1 + (idx / `NTT_BLOCK_WORDS) * BLOCK_ENTRIES
                 + `NTT_BLOCK_WORDS * `NTT_BLOCK_WORDS
                 + (idx % `NTT_BLOCK_WORDS) * `NTT_BLOCK_WORDS;
    endfunction

    task automatic check_value(input string name, input coeff_word_t got,
                               input coeff_word_t exp);
        if (got !== exp) begin
            $display("Error: %s is %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    // offers one word and returns on the edge that takes it
    // a nonzero min_wait means the buffer is draining and must hold the word back
    task automatic send_word(input coeff_word_t data, input int min_wait);
        int waited;
        waited   = 0;
        in_valid <= 1'b1;
        in_data  <= data;
        do begin
            @(posedge clk);
            waited++;
        end while (!in_ready);
        if (waited < min_wait) begin
            $display("input word was taken after %0d cycles while a block drained", waited);
            errors++;
        end
    endtask

    //========================================
    // stimulus
    //========================================
    initial begin : drive
        zeroize   = 1'b0;
        in_valid  = 1'b0;
        in_data   = '0;
        flushing  = 1'b1;
        hold_sink = 1'b0;
        $readmemh("ntt_input.hex", file_mem);
        twiddle = file_mem[0];
        while (reset_n !== 1'b1) @(posedge clk);
        // block 0 goes in once, its results are still inside at the zeroize pulse
        for (int r = 0; r < `NTT_BLOCK_WORDS; r++) begin
            send_word(word_at(input_base(0, r)), 0);
        end
        // two rows of block 0 go in again and are thrown away by zeroize
        send_word(word_at(input_base(0, 0)), `NTT_BLOCK_WORDS + 1);
        // the sink refuses words so the last column is still held at the pulse
        hold_sink <= 1'b1;
        send_word(word_at(input_base(0, 1)), 0);
        in_valid <= 1'b0;
        zeroize  <= 1'b1;
        @(posedge clk);
        zeroize   <= 1'b0;
        hold_sink <= 1'b0;
        flushing  <= 1'b0;
        @(posedge clk);
        check_value("out_valid_o", coeff_word_t'(out_valid), coeff_word_t'(1'b0));
        // every block back to back, a new block waits for four columns to leave
        for (int b = 0; b < NUM_BLOCKS; b++) begin
            for (int r = 0; r < `NTT_BLOCK_WORDS; r++) begin
                send_word(word_at(input_base(b, r)),
                          (b > 0 && r == 0) ? `NTT_BLOCK_WORDS + 1 : 0);
            end
        end
        in_valid <= 1'b0;
        while (recv_cnt < WORDS_TOTAL) @(posedge clk);
        // some idle cycles so that a repeated word would still show up
        repeat (8) @(posedge clk);
        $display("%0d errors, %0d of %0d words received", errors, recv_cnt, WORDS_TOTAL);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    //========================================
    // output side and timeout
    //========================================
    initial begin : monitor
        out_ready = 1'b0;
        lcg_state = 32'h8a8;
        cycle_cnt = 0;
        hold_prev = 1'b0;
        data_prev = '0;
        forever begin
            @(posedge clk);
            cycle_cnt++;
            if (cycle_cnt >= TIMEOUT_CYCLES) begin
                $display("output stalled with %0d of %0d words after %0d cycles",
                         recv_cnt, WORDS_TOTAL, cycle_cnt);
                $display("%0d errors", errors);
                $display("Test failed");
                $finish;
            end else begin
                // a word the sink refused must stay put
                if (hold_prev) begin
                    check_value("out_valid_o", coeff_word_t'(out_valid), coeff_word_t'(1'b1));
                    check_value("out_data_o", out_data, data_prev);
                end
                if (out_valid && out_ready && !flushing) begin
                    if (recv_cnt < WORDS_TOTAL) begin
                        check_value("out_data_o", out_data, word_at(expect_base(recv_cnt)));
                    end else begin
                        $display("an extra output word %h came after the last one", out_data);
                        errors++;
                    end
                    recv_cnt++;
                end
                // a zeroize edge drops the held word
                hold_prev = out_valid && !out_ready && !zeroize;
                data_prev = out_data;
                // the sink is ready about three cycles in four
                lcg_state = lcg_next(lcg_state);
                out_ready <= (lcg_state[17:16] != 2'b00) && !hold_sink;
            end
        end
    end

endmodule
